//--- common/bus_pkg.sv
package bus_pkg;

    localparam int BUS_WIDTH  = 32;
    localparam int ADDR_WIDTH = 4;     // small register window

    localparam logic [ADDR_WIDTH-1:0] DATA_ADDR   = 4'h0;
    localparam logic [ADDR_WIDTH-1:0] STATUS_ADDR = 4'h4;

    // read word seen by the bus master
    // data reads fill the byte view and status reads fill the flag view
    typedef union packed {
        struct packed {
            logic [23:0] pad;
            logic [7:0]  value;    // received byte or idle byte
        } data;
        struct packed {
            logic [28:0] pad;
            logic        tx_fault; // sticky, cleared by reset only
            logic        rx_ready; // chip holds a byte
            logic        tx_idle;  // bit 0
        } status;
    } bus_word_u;

endpackage

//--- common/uart_pkg.sv
package uart_pkg;

    // timer count width, large enough for the flag wait limit
    localparam int TIMER_WIDTH = 7;

    // cycles a strobe stays low
    localparam logic [TIMER_WIDTH-1:0] STROBE_CYCLES = 7'd2;

    // longest wait on tbre or tsre before a fault
    localparam logic [TIMER_WIDTH-1:0] WAIT_LIMIT = 7'd64;

    // returned on a data read with nothing to read
    localparam logic [7:0] IDLE_BYTE = 8'hff;

    typedef enum logic [2:0] {
        IDLE,
        WR_STROBE,     // uart_wrn low, byte on the pins
        WR_WAIT_TBRE,  // wait for transmit buffer empty
        WR_WAIT_TSRE,  // wait for transmit shift empty
        RD_STROBE      // uart_rdn low, chip drives the pins
    } serial_state_e;

endpackage

//--- serial/strobe_timer.sv
module strobe_timer (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            timer_load,
    input  logic [uart_pkg::TIMER_WIDTH-1:0] timer_len,
    output logic                            timer_expired
);

    logic [uart_pkg::TIMER_WIDTH-1:0] count;

    // load wins over the countdown
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count <= '0;
        end else if (timer_load) begin
            count <= timer_len;
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    assign timer_expired = (count == '0);

    // parked at zero until the next load
    a_no_underflow: assert property (
        @(posedge clk) disable iff (rst)
        (!timer_load && count == '0) |=> (count == '0)
    );

    // a strobe load never exceeds the flag wait limit
    a_len_range: assert property (
        @(posedge clk) disable iff (rst)
        timer_load |-> (timer_len < uart_pkg::WAIT_LIMIT)
    );

endmodule

//--- serial/uart_data_port.sv
module uart_data_port (
    input  logic       clk,
    input  logic       rst,
    input  logic       wr_req,
    input  logic [7:0] bus_wdata_byte,
    input  logic       drive_en,
    input  logic       capture,
    output logic [7:0] rx_byte,
    inout  wire  [7:0] uart_data
);

    logic [7:0] tx_byte;

    // hold the byte while it sits on the pins
    // a discarded write may land here later but is never driven
    always_ff @(posedge clk) begin
        if (wr_req && !drive_en) begin
            tx_byte <= bus_wdata_byte;
        end
    end

    // sampled at the edge where uart_rdn rises
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rx_byte <= uart_pkg::IDLE_BYTE;
        end else if (capture) begin
            rx_byte <= uart_data;
        end
    end

    assign uart_data = drive_en ? tx_byte : 8'bz;   // shared lines float otherwise

    // the chip owns the lines during a read
    a_no_capture_while_driving: assert property (
        @(posedge clk) disable iff (rst)
        capture |-> !drive_en
    );

endmodule

//--- serial/serial_fsm.sv
module serial_fsm (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            wr_req,
    input  logic                            rd_req,
    input  logic                            uart_dataready,
    input  logic                            uart_tbre,
    input  logic                            uart_tsre,
    input  logic                            timer_expired,
    output logic                            uart_rdn,
    output logic                            uart_wrn,
    output logic                            drive_en,
    output logic                            capture,
    output logic                            rd_done,
    output logic                            rd_empty,
    output logic                            tx_idle,
    output logic                            rx_ready,
    output logic                            tx_fault,
    output logic                            timer_load,
    output logic [uart_pkg::TIMER_WIDTH-1:0] timer_len
);

    uart_pkg::serial_state_e state, state_next;
    logic fault_set;

    // timer counts len down to zero, so len is one less than the wanted width
    always_comb begin
        state_next = state;
        timer_load = 1'b0;
        timer_len  = uart_pkg::STROBE_CYCLES - 1'b1;
        fault_set  = 1'b0;
        case (state)
            uart_pkg::IDLE: begin
                if (wr_req) begin
                    state_next = uart_pkg::WR_STROBE;
                    timer_load = 1'b1;
                end else if (rd_req && rx_ready) begin
                    state_next = uart_pkg::RD_STROBE;
                    timer_load = 1'b1;
                end
            end
            uart_pkg::WR_STROBE: begin
                if (timer_expired) begin
                    state_next = uart_pkg::WR_WAIT_TBRE;
                    timer_load = 1'b1;
                    timer_len  = uart_pkg::WAIT_LIMIT - 1'b1;
                end
            end
            uart_pkg::WR_WAIT_TBRE: begin
                if (uart_tbre) begin
                    state_next = uart_pkg::WR_WAIT_TSRE;
                    timer_load = 1'b1;    // fresh budget for the shift register
                    timer_len  = uart_pkg::WAIT_LIMIT - 1'b1;
                end else if (timer_expired) begin
                    state_next = uart_pkg::IDLE;
                    fault_set  = 1'b1;
                end
            end
            uart_pkg::WR_WAIT_TSRE: begin
                if (uart_tsre) begin
                    state_next = uart_pkg::IDLE;
                end else if (timer_expired) begin
                    state_next = uart_pkg::IDLE;
                    fault_set  = 1'b1;
                end
            end
            uart_pkg::RD_STROBE: begin
                if (timer_expired) state_next = uart_pkg::IDLE;
            end
            default: state_next = uart_pkg::IDLE;
        endcase
    end

    assign capture  = (state == uart_pkg::RD_STROBE) && timer_expired;
    // busy or nothing to read, answered without a strobe
    assign rd_empty = rd_req && (state != uart_pkg::IDLE || !rx_ready);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= uart_pkg::IDLE;
            uart_rdn <= 1'b1;
            uart_wrn <= 1'b1;
            drive_en <= 1'b0;
            rd_done  <= 1'b0;
            tx_idle  <= 1'b1;
            rx_ready <= 1'b0;
            tx_fault <= 1'b0;
        end else begin
            state    <= state_next;
            uart_wrn <= (state_next != uart_pkg::WR_STROBE);
            uart_rdn <= (state_next != uart_pkg::RD_STROBE);
            drive_en <= (state_next == uart_pkg::WR_STROBE);
            rd_done  <= capture;      // rx_byte valid from here
            tx_idle  <= (state_next == uart_pkg::IDLE);
            rx_ready <= uart_dataready;
            if (fault_set) tx_fault <= 1'b1;
        end
    end

    a_strobes_exclusive: assert property (
        @(posedge clk) disable iff (rst)
        !(!uart_rdn && !uart_wrn)
    );

    a_drive_only_when_not_reading: assert property (
        @(posedge clk) disable iff (rst)
        drive_en |-> uart_rdn
    );

endmodule

//--- source/serial_bus_slave.sv
module serial_bus_slave (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           bus_en,
    input  logic                           bus_we,
    input  logic [bus_pkg::ADDR_WIDTH-1:0] bus_addr,
    input  logic [7:0]                     rx_byte,
    input  logic                           rd_done,
    input  logic                           rd_empty,
    input  logic                           tx_idle,
    input  logic                           rx_ready,
    input  logic                           tx_fault,
    output bus_pkg::bus_word_u             bus_rdata,
    output logic                           bus_rvalid,
    output logic                           wr_req,
    output logic                           rd_req
);

    logic data_sel;
    logic status_rd;
    logic rvalid_q;
    bus_pkg::bus_word_u rdata_q;
    bus_pkg::bus_word_u rdata_next;

    assign data_sel  = (bus_addr == bus_pkg::DATA_ADDR);
    assign status_rd = bus_en && !bus_we && (bus_addr == bus_pkg::STATUS_ADDR);

    // data accesses go to the FSM, sampled on the same edge as the bus
    assign wr_req = bus_en && bus_we && data_sel;
    assign rd_req = bus_en && !bus_we && data_sel;

    // status and empty reads are answered from a register
    always_comb begin
        rdata_next = '0;
        if (status_rd) begin
            rdata_next.status.tx_fault = tx_fault;
            rdata_next.status.rx_ready = rx_ready;
            rdata_next.status.tx_idle  = tx_idle;
        end else begin
            rdata_next.data.value = uart_pkg::IDLE_BYTE;   // rd_empty case
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= status_rd || rd_empty;
        end
    end

    always_ff @(posedge clk) begin
        if (status_rd || rd_empty) begin
            rdata_q <= rdata_next;
        end
    end

    // a captured byte goes out in the rd_done cycle
    // at most one read is open so the sources never overlap
    always_comb begin
        bus_rvalid = rvalid_q || rd_done;
        bus_rdata  = rdata_q;
        if (rd_done) begin
            bus_rdata            = '0;
            bus_rdata.data.value = rx_byte;
        end
    end

    // one response per read
    a_single_rvalid: assert property (
        @(posedge clk) disable iff (rst)
        bus_rvalid |=> !bus_rvalid
    );

endmodule

//--- source/serial_port_top.sv
module serial_port_top (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           bus_en,
    input  logic                           bus_we,
    input  logic [bus_pkg::ADDR_WIDTH-1:0] bus_addr,
    input  logic [bus_pkg::BUS_WIDTH-1:0]  bus_wdata,
    output bus_pkg::bus_word_u             bus_rdata,
    output logic                           bus_rvalid,
    output logic                           uart_rdn,
    output logic                           uart_wrn,
    input  logic                           uart_dataready,
    input  logic                           uart_tbre,
    input  logic                           uart_tsre,
    inout  wire  [7:0]                     uart_data
);

    logic wr_req, rd_req, rd_done, rd_empty;
    logic tx_idle, rx_ready, tx_fault;
    logic drive_en, capture;
    logic timer_load, timer_expired;
    logic [uart_pkg::TIMER_WIDTH-1:0] timer_len;
    logic [7:0] rx_byte;

    serial_bus_slave u_bus_slave (
        .clk(clk), .rst(rst),
        .bus_en(bus_en), .bus_we(bus_we), .bus_addr(bus_addr),
        .rx_byte(rx_byte), .rd_done(rd_done), .rd_empty(rd_empty),
        .tx_idle(tx_idle), .rx_ready(rx_ready), .tx_fault(tx_fault),
        .bus_rdata(bus_rdata), .bus_rvalid(bus_rvalid),
        .wr_req(wr_req), .rd_req(rd_req)
    );

    serial_fsm u_fsm (
        .clk(clk), .rst(rst),
        .wr_req(wr_req), .rd_req(rd_req),
        .uart_dataready(uart_dataready), .uart_tbre(uart_tbre), .uart_tsre(uart_tsre),
        .timer_expired(timer_expired),
        .uart_rdn(uart_rdn), .uart_wrn(uart_wrn),
        .drive_en(drive_en), .capture(capture),
        .rd_done(rd_done), .rd_empty(rd_empty),
        .tx_idle(tx_idle), .rx_ready(rx_ready), .tx_fault(tx_fault),
        .timer_load(timer_load), .timer_len(timer_len)
    );

    strobe_timer u_timer (
        .clk(clk), .rst(rst),
        .timer_load(timer_load), .timer_len(timer_len),
        .timer_expired(timer_expired)
    );

    // only the low byte of a write reaches the chip
    uart_data_port u_data_port (
        .clk(clk), .rst(rst),
        .wr_req(wr_req), .bus_wdata_byte(bus_wdata[7:0]),
        .drive_en(drive_en), .capture(capture),
        .rx_byte(rx_byte), .uart_data(uart_data)
    );

endmodule

//--- test/tb_clock.sv
module tb_clock (
    output logic clk
);

    localparam int HALF_PERIOD = 5;   // period 10

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

endmodule

//--- test/uart_chip_model.sv
module uart_chip_model (
    input  logic       clk,
    input  logic       uart_rdn,
    input  logic       uart_wrn,
    input  logic       silent,          // tbre and tsre stay low while set
    input  logic       rx_push,
    input  logic [7:0] rx_push_byte,
    output logic       uart_dataready,
    output logic       uart_tbre,
    output logic       uart_tsre,
    output int         tx_count,
    output logic [7:0] tx_last,
    inout  wire  [7:0] uart_data
);

    logic [7:0] rx_q[$];
    logic [7:0] rx_head;
    logic [7:0] wr_byte;
    logic [7:0] push_byte_s;
    logic       rdn_q;
    logic       wrn_q;
    logic       push_s;
    logic       silent_s;
    int         tbre_wait;
    int         tsre_wait;
    int         seed;

    assign uart_data = uart_rdn ? 8'bz : rx_head;   // chip drives only under its read strobe

    // testbench controls are taken on the rising edge
    always @(posedge clk) begin
        push_s      <= rx_push;
        push_byte_s <= rx_push_byte;
        silent_s    <= silent;
    end

    initial begin
        seed           = 32'h36c78ff8;
        rdn_q          = 1'b1;
        wrn_q          = 1'b1;
        wr_byte        = 8'h00;
        rx_head        = 8'hff;
        uart_dataready = 1'b0;
        uart_tbre      = 1'b1;
        uart_tsre      = 1'b1;
        tx_count       = 0;
        tx_last        = 8'h00;
        tbre_wait      = 0;
        tsre_wait      = 0;
    end

    // chip pins change on the falling edge
    always @(negedge clk) begin
        if (push_s) rx_q.push_back(push_byte_s);
        if (uart_rdn && !rdn_q && rx_q.size() != 0) void'(rx_q.pop_front());
        if (!uart_wrn) wr_byte = uart_data;     // last value seen under the strobe
        if (uart_wrn && !wrn_q) begin
            tx_count++;
            tx_last   = wr_byte;
            uart_tbre = 1'b0;
            uart_tsre = 1'b0;
            tbre_wait = 1 + $unsigned($random(seed)) % 16;
            tsre_wait = tbre_wait + 1 + $unsigned($random(seed)) % 16;
        end else if (!silent_s) begin
            if (tbre_wait > 0) tbre_wait--;
            else uart_tbre = 1'b1;
            if (tsre_wait > 0) tsre_wait--;
            else uart_tsre = 1'b1;
        end
        rdn_q          = uart_rdn;
        wrn_q          = uart_wrn;
        uart_dataready = (rx_q.size() != 0);
        rx_head        = (rx_q.size() != 0) ? rx_q[0] : 8'hff;
    end

endmodule

//--- test/tb_serial_port.sv
module tb_serial_port;

    // strobe width, then the response cycle
    localparam int READ_LATENCY = uart_pkg::STROBE_CYCLES + 1;

    logic clk;
    logic rst;
    logic bus_en;
    logic bus_we;
    logic [bus_pkg::ADDR_WIDTH-1:0] bus_addr;
    logic [bus_pkg::BUS_WIDTH-1:0]  bus_wdata;
    bus_pkg::bus_word_u bus_rdata;
    logic bus_rvalid;
    logic uart_rdn;
    logic uart_wrn;
    logic uart_dataready;
    logic uart_tbre;
    logic uart_tsre;
    wire  [7:0] uart_data;
    logic silent;
    logic rx_push;
    logic [7:0] rx_push_byte;
    int   tx_count;
    logic [7:0] tx_last;

    // expected values set by the stimulus
    bus_pkg::bus_word_u exp_status;
    logic status_chk;
    logic read_full;
    logic no_rdn;
    logic [7:0] exp_byte;
    logic [7:0] exp_tx_byte;
    int   exp_tx_count;
    int   wrn_low_len = 0;
    int   mismatches;
    int   timeouts;
    logic status_rd;
    logic data_rd;

    tb_clock u_clock (.clk(clk));

    serial_port_top DUT (
        .clk(clk), .rst(rst),
        .bus_en(bus_en), .bus_we(bus_we), .bus_addr(bus_addr), .bus_wdata(bus_wdata),
        .bus_rdata(bus_rdata), .bus_rvalid(bus_rvalid),
        .uart_rdn(uart_rdn), .uart_wrn(uart_wrn), .uart_dataready(uart_dataready),
        .uart_tbre(uart_tbre), .uart_tsre(uart_tsre), .uart_data(uart_data)
    );

    uart_chip_model u_chip (
        .clk(clk), .uart_rdn(uart_rdn), .uart_wrn(uart_wrn), .silent(silent),
        .rx_push(rx_push), .rx_push_byte(rx_push_byte),
        .uart_dataready(uart_dataready), .uart_tbre(uart_tbre), .uart_tsre(uart_tsre),
        .tx_count(tx_count), .tx_last(tx_last), .uart_data(uart_data)
    );

    assign status_rd = bus_en && !bus_we && (bus_addr == bus_pkg::STATUS_ADDR);
    assign data_rd   = bus_en && !bus_we && (bus_addr == bus_pkg::DATA_ADDR);

    always @(posedge clk) begin
        wrn_low_len <= uart_wrn ? 0 : wrn_low_len + 1;   // low cycles of the current strobe
    end

    task automatic report_value(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        mismatches++;
        $display("[ERROR] %0t %s expected %h got %h", $time, name, expected, actual);
    endtask

    a_reset_state: assert property (@(posedge clk)
        $fell(rst) |-> uart_rdn && uart_wrn && !DUT.drive_en && !bus_rvalid)
        else report_value("{uart_rdn,uart_wrn,drive_en,bus_rvalid}", 4'b1100,
                          {uart_rdn, uart_wrn, DUT.drive_en, bus_rvalid});
    a_status_latency: assert property (@(posedge clk) disable iff (rst)
        status_rd |=> bus_rvalid)
        else report_value("bus_rvalid", 1, bus_rvalid);
    a_status_value: assert property (@(posedge clk) disable iff (rst)
        status_rd && status_chk |=> bus_rdata == exp_status)
        else report_value("bus_rdata", exp_status, bus_rdata);
    a_read_full: assert property (@(posedge clk) disable iff (rst)
        $past(data_rd && read_full, READ_LATENCY) |->
            bus_rvalid && bus_rdata.data.value == exp_byte)
        else report_value("bus_rdata", exp_byte, bus_rvalid ? bus_rdata : 32'hx);
    a_read_empty: assert property (@(posedge clk) disable iff (rst)
        data_rd && !read_full |=> bus_rvalid && bus_rdata.data.value == uart_pkg::IDLE_BYTE)
        else report_value("bus_rdata", uart_pkg::IDLE_BYTE, bus_rvalid ? bus_rdata : 32'hx);
    a_no_rdn: assert property (@(posedge clk) disable iff (rst)
        no_rdn |-> uart_rdn)
        else report_value("uart_rdn", 1, uart_rdn);
    a_wrn_width: assert property (@(posedge clk) disable iff (rst)
        $rose(uart_wrn) |-> wrn_low_len == uart_pkg::STROBE_CYCLES)
        else report_value("uart_wrn low cycles", uart_pkg::STROBE_CYCLES, wrn_low_len);
    a_tx_count: assert property (@(posedge clk) disable iff (rst)
        tx_count != $past(tx_count) |-> tx_count == exp_tx_count)
        else report_value("tx_count", exp_tx_count, tx_count);
    a_tx_byte: assert property (@(posedge clk) disable iff (rst)
        tx_count != $past(tx_count) |-> tx_last == exp_tx_byte)
        else report_value("tx_last", exp_tx_byte, tx_last);
    // the end of a write waits for the shift register
    a_idle_after_tsre: assert property (@(posedge clk) disable iff (rst)
        $rose(DUT.tx_idle) && !silent |-> $past(uart_tsre))
        else report_value("uart_tsre at tx_idle rise", 1, $past(uart_tsre));

    task automatic bus_read(input logic [3:0] addr, output bus_pkg::bus_word_u word);
        int n;
        @(negedge clk);
        bus_en   = 1'b1;
        bus_we   = 1'b0;
        bus_addr = addr;
        @(negedge clk);
        bus_en = 1'b0;
        n = 0;
        while (!bus_rvalid && n < 20) begin
            @(negedge clk);
            n++;
        end
        word = bus_rvalid ? bus_rdata : '0;
        if (!bus_rvalid) begin
            timeouts++;
            $display("timeout: no bus_rvalid for a read at address %0h", addr);
        end
    endtask

    task automatic bus_write(input logic [7:0] value);
        @(negedge clk);
        bus_en    = 1'b1;
        bus_we    = 1'b1;
        bus_addr  = bus_pkg::DATA_ADDR;
        bus_wdata = {24'h0, value};
        @(negedge clk);
        bus_en = 1'b0;
        bus_we = 1'b0;
    endtask

    task automatic send_byte(input logic [7:0] value);
        @(negedge clk);
        exp_tx_count++;
        exp_tx_byte = value;
        bus_write(value);
    endtask

    task automatic check_status(input logic fault, input logic idle);
        bus_pkg::bus_word_u word;
        @(negedge clk);
        exp_status = '0;
        exp_status.status.tx_fault = fault;
        exp_status.status.rx_ready = uart_dataready;
        exp_status.status.tx_idle  = idle;
        status_chk = 1'b1;
        bus_read(bus_pkg::STATUS_ADDR, word);
        status_chk = 1'b0;
    endtask

    task automatic read_byte(input logic full, input logic [7:0] value);
        bus_pkg::bus_word_u word;
        @(negedge clk);
        read_full = full;
        no_rdn    = !full;     // empty queue means no strobe at all
        exp_byte  = value;
        bus_read(bus_pkg::DATA_ADDR, word);
        read_full = 1'b0;
        no_rdn    = 1'b0;
    endtask

    task automatic push_rx(input logic [7:0] value);
        @(negedge clk);
        rx_push      = 1'b1;
        rx_push_byte = value;
        @(negedge clk);
        rx_push = 1'b0;
        @(negedge clk);
    endtask

    task automatic wait_tx_idle();
        bus_pkg::bus_word_u word;
        int n;
        n = 0;
        word = '0;
        while (!word.status.tx_idle && n < 100) begin
            bus_read(bus_pkg::STATUS_ADDR, word);
            n++;
        end
        if (!word.status.tx_idle) begin
            timeouts++;
            $display("timeout: the transmitter never returned to idle");
        end
    endtask

    task automatic wait_chip_idle();
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!uart_tsre && n < 100);
        if (!uart_tsre) begin
            timeouts++;
            $display("timeout: the chip never raised uart_tsre");
        end
    endtask

    initial begin
        rst          = 1'b1;
        bus_en       = 1'b0;
        bus_we       = 1'b0;
        bus_addr     = '0;
        bus_wdata    = '0;
        silent       = 1'b0;
        rx_push      = 1'b0;
        rx_push_byte = 8'h00;
        exp_status   = '0;
        status_chk   = 1'b0;
        read_full    = 1'b0;
        no_rdn       = 1'b0;
        exp_byte     = 8'h00;
        exp_tx_byte  = 8'h00;
        exp_tx_count = 0;
        mismatches   = 0;
        timeouts     = 0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        check_status(1'b0, 1'b1);
        push_rx(8'ha7);
        check_status(1'b0, 1'b1);     // rx_ready follows the chip now
        read_byte(1'b1, 8'ha7);
        read_byte(1'b0, uart_pkg::IDLE_BYTE);

        send_byte(8'h3c);
        bus_write(8'hee);             // busy, must be dropped
        wait_tx_idle();
        send_byte(8'h81);
        wait_tx_idle();

        @(negedge clk);
        silent = 1'b1;
        send_byte(8'h5a);
        wait_tx_idle();
        check_status(1'b1, 1'b1);
        @(negedge clk);
        silent = 1'b0;
        wait_chip_idle();
        send_byte(8'hc3);
        wait_tx_idle();
        check_status(1'b1, 1'b1);     // fault is sticky

        repeat (4) @(negedge clk);
        a_log_total: assert (tx_count == exp_tx_count)
            else report_value("tx_count", exp_tx_count, tx_count);

        $display("errors: %0d value mismatches, %0d timeouts", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- all.f
common/bus_pkg.sv
common/uart_pkg.sv
serial/strobe_timer.sv
serial/uart_data_port.sv
serial/serial_fsm.sv
source/serial_bus_slave.sv
source/serial_port_top.sv
test/tb_clock.sv
test/uart_chip_model.sv
test/tb_serial_port.sv

//--- Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_serial_port \
		-f all.f -o sim_serial_port
	./obj_dir/sim_serial_port | tee $(LOG)
	grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
